//--- src/mult_pkg.sv
`default_nettype none

package mult_pkg;

	// operand and product widths
	localparam int x_w = 16;
	localparam int y_w = 12;
	localparam int p_w = x_w + y_w;

	// apb bus
	localparam int addr_w = 4;
	localparam int data_w = 32;

	localparam logic [addr_w-1:0] addr_operand = 4'h0;
	localparam logic [addr_w-1:0] addr_product = 4'h4;
	localparam logic [addr_w-1:0] addr_status = 4'h8;

	// baugh-wooley needs 2^(x_w-1) + 2^(y_w-1) + 2^(p_w-1) added to the array.
	// the adder injects 2^y_w and flips the top bit, so the array adds the rest
	localparam logic [x_w-1:0] bw_fix =
		x_w'((1 << (x_w - 1)) + (1 << (y_w - 1)) - (1 << y_w));

	// one operand word, seen raw on the bus or split into x and y
	typedef union packed {
		logic [data_w-1:0] raw;
		struct packed {
			logic [data_w-p_w-1:0] unused;
			logic [y_w-1:0] y;
			logic [x_w-1:0] x;
		} f;
	} op_word_u;

endpackage

`default_nettype wire

//--- src/csa_if.sv
`timescale 1ns/1ps
`default_nettype none

// carry-save result of the array, handed to the final adder
interface csa_if;

	logic [mult_pkg::x_w-1:0] sum; // last row sums
	logic [mult_pkg::x_w-2:0] carry; // last row carries
	logic [mult_pkg::y_w-1:0] low; // one product bit per row
	logic valid;

	modport array (
		output sum,
		output carry,
		output low,
		output valid
	);

	modport adder (
		input sum,
		input carry,
		input low,
		input valid
	);

endinterface

`default_nettype wire

//--- src/apb_regs.sv
`timescale 1ns/1ps
`default_nettype none

module apb_regs (
	input logic pclk,
	input logic rst_n,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic [mult_pkg::addr_w-1:0] paddr,
	input logic [mult_pkg::data_w-1:0] pwdata,
	input logic [mult_pkg::p_w-1:0] product,
	input logic product_valid,
	output logic [mult_pkg::data_w-1:0] prdata,
	output logic pready,
	output logic pslverr,
	output mult_pkg::op_word_u op,
	output logic op_valid
);

	logic access;
	logic sel_operand;
	logic sel_product;
	logic sel_status;
	logic busy;
	logic [1:0] inflight; // products still in the pipe
	mult_pkg::op_word_u operand_q;
	logic [mult_pkg::p_w-1:0] product_q;

	assign access = psel & penable;
	assign sel_operand = paddr == mult_pkg::addr_operand;
	assign sel_product = paddr == mult_pkg::addr_product;
	assign sel_status = paddr == mult_pkg::addr_status;

	assign pready = 1'b1; // never wait
	// unmapped address, or write to a read-only register
	assign pslverr = access &
		(~(sel_operand | sel_product | sel_status) | (pwrite & ~sel_operand));
	assign op_valid = access & pwrite & sel_operand;

	// next value of OPERAND, so the array sees the new word in the access phase
	always_comb begin
		op = operand_q;
		if (op_valid) begin
			op.raw = pwdata;
		end
	end

	always_ff @(posedge pclk) begin
		if (!rst_n) begin
			operand_q <= '0;
		end else begin
			operand_q <= op;
		end
	end

	always_ff @(posedge pclk) begin
		if (!rst_n) begin
			product_q <= '0;
		end else if (product_valid) begin
			product_q <= product;
		end
	end

	// at most two in flight, array stage and adder stage
	always_ff @(posedge pclk) begin
		if (!rst_n) begin
			inflight <= 2'd0;
		end else begin
			case ({op_valid, product_valid})
				2'b10: inflight <= inflight + 2'd1;
				2'b01: inflight <= inflight - 2'd1;
				default: inflight <= inflight;
			endcase
		end
	end

	assign busy = inflight != 2'd0;

	always_comb begin
		case (paddr)
			mult_pkg::addr_operand: prdata = operand_q.raw;
			mult_pkg::addr_product: begin
				prdata = {{(mult_pkg::data_w - mult_pkg::p_w){product_q[mult_pkg::p_w-1]}},
					product_q}; // sign extended
			end
			mult_pkg::addr_status: prdata = {{(mult_pkg::data_w - 1){1'b0}}, busy};
			default: prdata = '0;
		endcase
	end

endmodule

`default_nettype wire

//--- src/csa_array.sv
`timescale 1ns/1ps
`default_nettype none

module csa_array (
	input logic pclk,
	input logic rst_n,
	input mult_pkg::op_word_u op,
	input logic op_valid,
	csa_if.array cs
);

	logic [mult_pkg::x_w-1:0] x;
	logic [mult_pkg::y_w-1:0] y;
	logic [mult_pkg::x_w-1:0] pp [mult_pkg::y_w]; // partial product rows
	logic [mult_pkg::x_w-1:0] s_row [mult_pkg::y_w]; // running sums, row i weight 2^i
	logic [mult_pkg::x_w-2:0] c_row [mult_pkg::y_w]; // running carries
	logic [mult_pkg::y_w-1:0] low_c;

	assign x = op.f.x;
	assign y = op.f.y;

	// and terms, nand on the sign column and on the sign row
	// the sign x sign term stays a plain and
	for (genvar i = 0; i < mult_pkg::y_w; i++) begin : g_pp
		if (i == mult_pkg::y_w - 1) begin : g_sign_row
			assign pp[i] = (x & {mult_pkg::x_w{y[i]}}) ^
				{1'b0, {(mult_pkg::x_w - 1){1'b1}}};
		end else begin : g_row
			assign pp[i] = (x & {mult_pkg::x_w{y[i]}}) ^
				{1'b1, {(mult_pkg::x_w - 1){1'b0}}};
		end
	end

	assign s_row[0] = pp[0];
	// row 0 carries seed the correction constant
	// its zero bits reduce row 1 to half adders
	assign c_row[0] = mult_pkg::bw_fix[mult_pkg::x_w-1:1];

	for (genvar i = 1; i < mult_pkg::y_w; i++) begin : g_red
		logic [mult_pkg::x_w-2:0] a;
		logic [mult_pkg::x_w-2:0] b;

		assign a = pp[i][mult_pkg::x_w-2:0];
		assign b = s_row[i-1][mult_pkg::x_w-1:1]; // previous row shifted down one
		// top bit of each row passes straight to the next row
		assign s_row[i] = {pp[i][mult_pkg::x_w-1], a ^ b ^ c_row[i-1]};
		assign c_row[i] = (a & b) | (c_row[i-1] & (a ^ b));
	end

	// one finished product bit drops out per row
	always_comb begin
		for (int i = 0; i < mult_pkg::y_w; i++) begin
			low_c[i] = s_row[i][0];
		end
	end

	always_ff @(posedge pclk) begin
		if (!rst_n) begin
			cs.valid <= 1'b0;
		end else begin
			cs.valid <= op_valid;
		end
	end

	always_ff @(posedge pclk) begin
		cs.sum <= s_row[mult_pkg::y_w-1];
		cs.carry <= c_row[mult_pkg::y_w-1];
		cs.low <= low_c;
	end

endmodule

`default_nettype wire

//--- src/cpa_final.sv
`timescale 1ns/1ps
`default_nettype none

module cpa_final (
	input logic pclk,
	input logic rst_n,
	csa_if.adder cs,
	output logic [mult_pkg::p_w-1:0] product,
	output logic product_valid
);

	logic [mult_pkg::x_w-1:0] rc; // ripple carries
	logic [mult_pkg::x_w-2:0] hi; // product bits above the low ones

	assign rc[0] = 1'b1; // constant one of the baugh-wooley correction

	// carries line up with the sums shifted down by one
	for (genvar j = 0; j < mult_pkg::x_w - 1; j++) begin : g_rca
		logic a;
		logic b;

		assign a = cs.carry[j];
		assign b = cs.sum[j+1];
		assign hi[j] = a ^ b ^ rc[j];
		assign rc[j+1] = (a & b) | (rc[j] & (a ^ b));
	end

	always_ff @(posedge pclk) begin
		if (!rst_n) begin
			product_valid <= 1'b0;
		end else begin
			product_valid <= cs.valid;
		end
	end

	// inverted carry out gives the sign bit
	always_ff @(posedge pclk) begin
		product <= {~rc[mult_pkg::x_w-1], hi, cs.low};
	end

endmodule

`default_nettype wire

//--- src/csa_mult_apb.sv
`timescale 1ns/1ps
`default_nettype none

module csa_mult_apb (
	input logic pclk,
	input logic rst_n,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic [mult_pkg::addr_w-1:0] paddr,
	input logic [mult_pkg::data_w-1:0] pwdata,
	output logic [mult_pkg::data_w-1:0] prdata,
	output logic pready,
	output logic pslverr
);

	mult_pkg::op_word_u op;
	logic op_valid;
	logic [mult_pkg::p_w-1:0] product;
	logic product_valid;

	csa_if cs_i ();

	apb_regs regs_i (
		.pclk(pclk),
		.rst_n(rst_n),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.pwdata(pwdata),
		.product(product),
		.product_valid(product_valid),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr),
		.op(op),
		.op_valid(op_valid)
	);

	// stage 1, partial products and carry-save rows
	csa_array array_i (
		.pclk(pclk),
		.rst_n(rst_n),
		.op(op),
		.op_valid(op_valid),
		.cs(cs_i.array)
	);

	// stage 2
	cpa_final adder_i (
		.pclk(pclk),
		.rst_n(rst_n),
		.cs(cs_i.adder),
		.product(product),
		.product_valid(product_valid)
	);

endmodule

`default_nettype wire

//--- testbench/csa_mult_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module csa_mult_assertions (
	input logic pclk,
	input logic rst_n,
	input logic psel,
	input logic penable,
	input logic pready,
	input logic pslverr,
	input logic op_valid,
	input logic product_valid,
	input logic busy
);

	int fail_count = 0; // read by the testbench at the end

	a_pready: assert property (@(posedge pclk) disable iff (!rst_n) pready)
	else begin
		$error("pready dropped low");
		fail_count++;
	end

	a_pslverr_access: assert property (@(posedge pclk) disable iff (!rst_n)
		pslverr |-> psel && penable)
	else begin
		$error("pslverr outside an access phase");
		fail_count++;
	end

	// exactly two cycles, both ways
	a_latency: assert property (@(posedge pclk) disable iff (!rst_n)
		op_valid |-> ##2 product_valid)
	else begin
		$error("product_valid missing two cycles after op_valid");
		fail_count++;
	end

	a_no_stray_product: assert property (@(posedge pclk) disable iff (!rst_n)
		product_valid |-> $past(op_valid, 2))
	else begin
		$error("product_valid without op_valid two cycles before");
		fail_count++;
	end

	a_busy_clears: assert property (@(posedge pclk) disable iff (!rst_n)
		op_valid ##1 (!op_valid) [*2] |=> !busy)
	else begin
		$error("busy still high three cycles after the last operand");
		fail_count++;
	end

endmodule

bind apb_regs csa_mult_assertions chk_i (
	.pclk(pclk),
	.rst_n(rst_n),
	.psel(psel),
	.penable(penable),
	.pready(pready),
	.pslverr(pslverr),
	.op_valid(op_valid),
	.product_valid(product_valid),
	.busy(busy)
);

`default_nettype wire

//--- testbench/tb_csa_mult.sv
`timescale 1ns/1ps
`default_nettype none

module tb_csa_mult;

	localparam int timeout_cycles = 20;

	logic pclk;
	logic rst_n;
	logic psel;
	logic penable;
	logic pwrite;
	logic [mult_pkg::addr_w-1:0] paddr;
	logic [mult_pkg::data_w-1:0] pwdata;
	logic [mult_pkg::data_w-1:0] prdata;
	logic pready;
	logic pslverr;
	integer seed;

	csa_mult_apb dut_i (
		.pclk(pclk),
		.rst_n(rst_n),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr)
	);

	initial begin
		pclk = 1'b0;
		forever #4 pclk = ~pclk;
	end

	task automatic fail_run();
		$display("** FAIL **");
		$fatal(1, "run stopped at %0t", $time);
	endtask

	task automatic check_value(input string name, input logic [31:0] exp,
		input logic [31:0] got);
		assert (got === exp) else begin
			$display("ERR %0t %s expected %h actual %h", $time, name, exp, got);
			fail_run();
		end
	endtask

	// bound assertions count their failures
	always @(negedge pclk) begin
		assert (dut_i.regs_i.chk_i.fail_count == 0) else begin
			$display("a bound assertion failed by %0t", $time);
			fail_run();
		end
	end

	// setup then access, sampled mid-cycle
	task automatic apb_access(input logic wr, input logic [mult_pkg::addr_w-1:0] a,
		input logic [31:0] wd, output logic [31:0] rd, output logic err);
		int n;
		psel = 1'b1;
		penable = 1'b0;
		pwrite = wr;
		paddr = a;
		pwdata = wd;
		@(posedge pclk);
		#1 penable = 1'b1;
		n = 0;
		@(negedge pclk);
		while (!pready) begin
			n++;
			if (n > timeout_cycles) begin
				$display("timeout, pready stayed low in the access phase");
				fail_run();
			end
			@(negedge pclk);
		end
		rd = prdata;
		err = pslverr;
		@(posedge pclk);
		#1;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
	endtask

	task automatic idle(input int n);
		repeat (n) @(posedge pclk);
		#1;
	endtask

	task automatic write_check(input logic [mult_pkg::addr_w-1:0] a, input logic [31:0] d);
		logic [31:0] rd;
		logic err;
		apb_access(1'b1, a, d, rd, err);
		check_value("pslverr", 32'd0, {31'd0, err});
		if (a == mult_pkg::addr_operand) idle(2); // product lands two cycles later
	endtask

	task automatic read_check(input logic [mult_pkg::addr_w-1:0] a, input logic [31:0] e);
		logic [31:0] rd;
		logic err;
		apb_access(1'b0, a, 32'd0, rd, err);
		check_value("prdata", e, rd);
		check_value("pslverr", 32'd0, {31'd0, err});
	endtask

	// illegal write, then read back to see nothing moved
	task automatic error_access(input logic [mult_pkg::addr_w-1:0] a, input logic [31:0] d,
		input logic [31:0] e);
		logic [31:0] rd;
		logic err;
		logic mapped;
		mapped = a == mult_pkg::addr_operand || a == mult_pkg::addr_product ||
			a == mult_pkg::addr_status;
		apb_access(1'b1, a, d, rd, err);
		check_value("pslverr", 32'd1, {31'd0, err});
		apb_access(1'b0, a, 32'd0, rd, err);
		check_value("prdata", e, rd);
		check_value("pslverr", {31'd0, !mapped}, {31'd0, err});
	endtask

	function automatic logic [31:0] signed_product(input logic [31:0] w);
		logic signed [31:0] p;
		p = $signed(w[mult_pkg::x_w-1:0]) * $signed(w[mult_pkg::p_w-1:mult_pkg::x_w]);
		return p;
	endfunction

	initial begin
		integer fd;
		integer code;
		logic [7:0] kind;
		logic [mult_pkg::addr_w-1:0] a;
		logic [31:0] d;
		logic [31:0] e;
		logic [8*120-1:0] rest;
		seed = 32'heb76;
		rst_n = 1'b0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		repeat (16) @(posedge pclk);
		#1 rst_n = 1'b1;
		idle(1);
		fd = $fopen("testbench/csa_mult_testdata.txt", "r");
		if (fd == 0) begin
			$display("cannot open testbench/csa_mult_testdata.txt");
			fail_run();
		end
		while ($fscanf(fd, "%s", kind) == 1) begin
			if (kind == "#") begin
				code = $fgets(rest, fd); // rest of a comment line
			end else begin
				code = $fscanf(fd, "%h %h %h", a, d, e);
				if (code != 3) begin
					$display("malformed line in the test data");
					fail_run();
				end
				case (kind)
					"W": write_check(a, d);
					"R": read_check(a, e);
					"E": error_access(a, d, e);
					"B": run_pairs(d, e[0]);
					default: begin
						$display("unknown access kind in the test data");
						fail_run();
					end
				endcase
			end
		end
		$fclose(fd);
		if (dut_i.regs_i.chk_i.fail_count == 0) begin
			$display("** PASS **");
			$finish;
		end else begin
			$display("a bound assertion failed during the run");
			fail_run();
		end
	end

	// each pair checked, or a back-to-back burst checked at the end
	task automatic run_pairs(input int n, input logic burst);
		logic [31:0] w;
		logic [31:0] rd;
		logic err;
		w = 32'd0;
		for (int i = 0; i < n; i++) begin
			w = $random(seed);
			apb_access(1'b1, mult_pkg::addr_operand, w, rd, err);
			check_value("pslverr", 32'd0, {31'd0, err});
			if (!burst) begin
				idle(2);
				read_check(mult_pkg::addr_product, signed_product(w));
				read_check(mult_pkg::addr_operand, w);
			end
		end
		if (burst) begin
			idle(2);
			read_check(mult_pkg::addr_product, signed_product(w));
			read_check(mult_pkg::addr_status, 32'd0);
			read_check(mult_pkg::addr_operand, w);
		end
	endtask

endmodule

`default_nettype wire

//--- files.f
src/mult_pkg.sv
src/csa_if.sv
src/apb_regs.sv
src/csa_array.sv
src/cpa_final.sv
src/csa_mult_apb.sv
testbench/csa_mult_assertions.sv
testbench/tb_csa_mult.sv

//--- testbench/csa_mult_testdata.txt
# kind addr data expected, fields in hex
# W write, R read and compare, E illegal write then read back, B random pairs
# for B data is the pair count, expected 1 runs them back to back
R 4 00000000 00000000
R 0 00000000 00000000
R 8 00000000 00000000
W 0 00000000 00000000
R 4 00000000 00000000
W 0 08008000 00000000
R 4 00000000 04000000
R 0 00000000 08008000
W 0 07FF8000 00000000
R 4 00000000 FC008000
W 0 08007FFF 00000000
R 4 00000000 FC000800
W 0 07FF7FFF 00000000
R 4 00000000 03FF7801
W 0 AFFFFFFF 00000000
R 4 00000000 00000001
R 0 00000000 AFFFFFFF
R 8 00000000 00000000
E 4 12345678 00000001
E 8 FFFFFFFF 00000000
E C 0000ABCD 00000000
E 3 00000001 00000000
R 4 00000000 00000001
B 0 00000008 00000000
B 0 00000006 00000001
R 8 00000000 00000000
